/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module decodeStageTb -f all.f -Mdir obj_dir
	./obj_dir/VdecodeStageTb | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+logic
logic/rvPkg.sv
logic/decodeBus.sv
logic/controlMain.sv
logic/immGen.sv
logic/aluControl.sv
logic/regFile.sv
logic/idExReg.sv
logic/decodeStage.sv
testbench/tbClock.sv
testbench/decodeStageTb.sv

/* logic/aluControl.sv */
`default_nettype none

`include "rvParams.svh"

module aluControl (
	input  logic [`FUNCT3_W-1:0] funct3,
	input  logic                 funct7b5,
	decodeBus.producer           bus
);
	import rvPkg::*;

	aluOpT arith;

	// Shared funct3 map for register and immediate forms.
	always_comb begin
		case (funct3)
			3'b000:  arith = (funct7b5 && bus.ctrl.aluCntrl == aluR) ? opSub : opAdd;
			3'b001:  arith = opSll;
			3'b010:  arith = opSlt;
			3'b011:  arith = opSltu;
			3'b100:  arith = opXor;
			3'b101:  arith = funct7b5 ? opSra : opSrl;
			3'b110:  arith = opOr;
			default: arith = opAnd;
		endcase
	end

	always_comb begin
		case (bus.ctrl.aluCntrl)
			// Class aluR without a write is the unknown opcode default.
			aluR:      bus.aluOp = bus.ctrl.regWrite ? arith : opAdd;
			aluIComp:  bus.aluOp = arith;
			aluBranch: bus.aluOp = opSub; // Compare by subtraction.
			aluLui:    bus.aluOp = opPassB;
			default:   bus.aluOp = opAdd;
		endcase
	end

endmodule

`default_nettype wire

/* logic/controlMain.sv */
`default_nettype none

`include "rvParams.svh"

module controlMain (
	input  logic [`OPCODE_W-1:0] opcode,
	decodeBus.producer           bus
);
	import rvPkg::*;

	always_comb begin
		bus.ctrl = '0; // Unknown opcode stays all zero.
		bus.ctrl.aluCntrl = aluR;
		case (opcode)
			`R_FORMAT: begin
				bus.ctrl.regDst   = 1'b1;
				bus.ctrl.regWrite = 1'b1;
				bus.ctrl.aluCntrl = aluR;
			end
			`I_COMP_FORMAT: begin
				bus.ctrl.regDst   = 1'b1;
				bus.ctrl.aluSrc   = 1'b1;
				bus.ctrl.regWrite = 1'b1;
				bus.ctrl.aluCntrl = aluIComp;
			end
			`I_LOAD_FORMAT: begin
				bus.ctrl.regDst   = 1'b1;
				bus.ctrl.memRead  = 1'b1;
				bus.ctrl.memToReg = 1'b1;
				bus.ctrl.aluSrc   = 1'b1;
				bus.ctrl.regWrite = 1'b1;
				bus.ctrl.aluCntrl = aluLoadStore;
			end
			`I_JALR_FORMAT: begin
				bus.ctrl.regDst   = 1'b1;
				bus.ctrl.regWrite = 1'b1;
				bus.ctrl.jump     = 1'b1;
				bus.ctrl.inAIsPc  = 1'b1; // ALU forms the link address.
				bus.ctrl.aluCntrl = aluJ;
			end
			`S_FORMAT: begin
				bus.ctrl.memWrite = 1'b1;
				bus.ctrl.aluSrc   = 1'b1;
				bus.ctrl.aluCntrl = aluLoadStore;
			end
			`B_FORMAT: begin
				bus.ctrl.branch   = 1'b1;
				bus.ctrl.aluCntrl = aluBranch;
			end
			`J_FORMAT: begin
				bus.ctrl.regDst   = 1'b1;
				bus.ctrl.regWrite = 1'b1;
				bus.ctrl.jump     = 1'b1;
				bus.ctrl.inAIsPc  = 1'b1;
				bus.ctrl.aluCntrl = aluJ;
			end
			`U_FORMAT_LUI: begin
				bus.ctrl.regDst   = 1'b1;
				bus.ctrl.aluSrc   = 1'b1;
				bus.ctrl.regWrite = 1'b1;
				bus.ctrl.aluCntrl = aluLui;
			end
			`U_FORMAT_AUIPC: begin
				bus.ctrl.regDst   = 1'b1;
				bus.ctrl.aluSrc   = 1'b1;
				bus.ctrl.regWrite = 1'b1;
				bus.ctrl.inAIsPc  = 1'b1;
				bus.ctrl.aluCntrl = aluAuipc;
			end
			default: begin
				bus.ctrl.aluCntrl = aluR;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/decodeBus.sv */
`default_nettype none

`include "rvParams.svh"

interface decodeBus;
	import rvPkg::*;

	ctrlT             ctrl;
	aluOpT            aluOp;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;

	// Decode blocks. aluControl also reads ctrl through here.
	modport producer (output ctrl, output aluOp, output imm,
		output rs1Data, output rs2Data);

	modport consumer (input ctrl, input aluOp, input imm,
		input rs1Data, input rs2Data);

endinterface

`default_nettype wire

/* logic/decodeStage.sv */
`default_nettype none

`include "rvParams.svh"

module decodeStage (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic [`XLEN-1:0]       instr,
	input  logic [`XLEN-1:0]       pc,
	input  logic                   inValid,
	input  logic                   stall,
	input  logic                   flush,
	input  logic                   wbEn,
	input  logic [`REG_ADDR_W-1:0] wbAddr,
	input  logic [`XLEN-1:0]       wbData,
	output logic                   outValid,
	output logic                   regDst,
	output logic                   branch,
	output logic                   memRead,
	output logic                   memWrite,
	output logic                   memToReg,
	output logic                   aluSrc,
	output logic                   regWrite,
	output logic                   jump,
	output logic                   inAIsPc,
	output rvPkg::aluOpT           aluOp,
	output logic [`XLEN-1:0]       outPc,
	output logic [`XLEN-1:0]       rs1Data,
	output logic [`XLEN-1:0]       rs2Data,
	output logic [`XLEN-1:0]       imm,
	output logic [`REG_ADDR_W-1:0] rd,
	output logic [`FUNCT3_W-1:0]   funct3
);
	import rvPkg::*;

	idExT idEx;

	decodeBus bus ();

	controlMain uControlMain (.opcode(instr[6:0]), .bus(bus.producer));

	immGen uImmGen (.instr(instr), .bus(bus.producer));

	aluControl uAluControl (
		.funct3   (instr[14:12]),
		.funct7b5 (instr[30]),
		.bus      (bus.producer)
	);

	regFile uRegFile (
		.clock  (clock),
		.arstN  (arstN),
		.rs1    (instr[19:15]),
		.rs2    (instr[24:20]),
		.wbEn   (wbEn),
		.wbAddr (wbAddr),
		.wbData (wbData),
		.bus    (bus.producer)
	);

	idExReg uIdExReg (
		.clock   (clock),
		.arstN   (arstN),
		.stall   (stall),
		.flush   (flush),
		.inValid (inValid),
		.pc      (pc),
		.rd      (instr[11:7]),
		.funct3  (instr[14:12]),
		.bus     (bus.consumer),
		.idEx    (idEx)
	);

	assign outValid = idEx.valid;
	assign regDst   = idEx.ctrl.regDst;
	assign branch   = idEx.ctrl.branch;
	assign memRead  = idEx.ctrl.memRead;
	assign memWrite = idEx.ctrl.memWrite;
	assign memToReg = idEx.ctrl.memToReg;
	assign aluSrc   = idEx.ctrl.aluSrc;
	assign regWrite = idEx.ctrl.regWrite;
	assign jump     = idEx.ctrl.jump;
	assign inAIsPc  = idEx.ctrl.inAIsPc;
	assign aluOp    = idEx.aluOp;
	assign outPc    = idEx.pc;
	assign rs1Data  = idEx.rs1Data;
	assign rs2Data  = idEx.rs2Data;
	assign imm      = idEx.imm;
	assign rd       = idEx.rd;
	assign funct3   = idEx.funct3;

endmodule

`default_nettype wire

/* logic/idExReg.sv */
`default_nettype none

`include "rvParams.svh"

module idExReg (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic                   stall,
	input  logic                   flush,
	input  logic                   inValid,
	input  logic [`XLEN-1:0]       pc,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic [`FUNCT3_W-1:0]   funct3,
	decodeBus.consumer             bus,
	output rvPkg::idExT            idEx
);
	import rvPkg::*;

	idExT next;

	always_comb begin
		next.valid   = inValid;
		next.ctrl    = inValid ? bus.ctrl : '0; // Invalid slot becomes a bubble.
		next.aluOp   = bus.aluOp;
		next.pc      = pc;
		next.rs1Data = bus.rs1Data;
		next.rs2Data = bus.rs2Data;
		next.imm     = bus.imm;
		next.rd      = rd;
		next.funct3  = funct3;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else if (flush) begin // Flush wins over stall.
			idEx.valid <= 1'b0;
			idEx.ctrl  <= '0;
		end else if (!stall) begin
			idEx <= next;
		end
	end

endmodule

`default_nettype wire

/* logic/immGen.sv */
`default_nettype none

`include "rvParams.svh"

module immGen (
	input  logic [`XLEN-1:0] instr,
	decodeBus.producer       bus
);

	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (instr[`OPCODE_W-1:0])
			`I_COMP_FORMAT,
			`I_LOAD_FORMAT,
			`I_JALR_FORMAT:
				bus.imm = {{20{sign}}, instr[31:20]};
			`S_FORMAT:
				bus.imm = {{20{sign}}, instr[31:25], instr[11:7]};
			`B_FORMAT: // Halfword offset.
				bus.imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			`J_FORMAT:
				bus.imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			`U_FORMAT_LUI,
			`U_FORMAT_AUIPC:
				bus.imm = {instr[31:12], 12'b0};
			default:
				bus.imm = '0; // R-type has no immediate.
		endcase
	end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none

`include "rvParams.svh"

module regFile (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	input  logic                   wbEn,
	input  logic [`REG_ADDR_W-1:0] wbAddr,
	input  logic [`XLEN-1:0]       wbData,
	decodeBus.producer             bus
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	// x0 reads zero; a write in flight is passed through.
	function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wbEn && wbAddr == addr)
			return wbData;
		return regs[addr];
	endfunction

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wbEn && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

	always_comb begin
		bus.rs1Data = readPort(rs1);
		bus.rs2Data = readPort(rs2);
	end

endmodule

`default_nettype wire

/* logic/rvParams.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and register file sizes.
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// Instruction field widths.
`define OPCODE_W    7
`define FUNCT3_W    3

// RV32I major opcodes.
`define R_FORMAT       7'b0110011
`define I_COMP_FORMAT  7'b0010011
`define I_LOAD_FORMAT  7'b0000011
`define I_JALR_FORMAT  7'b1100111
`define S_FORMAT       7'b0100011
`define B_FORMAT       7'b1100011
`define J_FORMAT       7'b1101111
`define U_FORMAT_LUI   7'b0110111
`define U_FORMAT_AUIPC 7'b0010111

// ALU control classes from main control.
`define ALU_CNTRL_W    3
`define ALU_R          3'b000
`define ALU_I_COMP     3'b001
`define ALU_LOAD_STORE 3'b010
`define ALU_BRANCH     3'b011
`define ALU_J          3'b100
`define ALU_LUI        3'b101
`define ALU_AUIPC      3'b110

// Concrete ALU operation width.
`define ALU_OP_W    4

`endif

/* logic/rvPkg.sv */
`default_nettype none

`include "rvParams.svh"

package rvPkg;

	typedef enum logic [`ALU_CNTRL_W-1:0] {
		aluR         = `ALU_R,
		aluIComp     = `ALU_I_COMP,
		aluLoadStore = `ALU_LOAD_STORE,
		aluBranch    = `ALU_BRANCH,
		aluJ         = `ALU_J,
		aluLui       = `ALU_LUI,
		aluAuipc     = `ALU_AUIPC
	} aluCntrlT;

	// Zero is add, so a cleared register decodes as add.
	typedef enum logic [`ALU_OP_W-1:0] {
		opAdd   = 4'd0,
		opSub   = 4'd1,
		opSll   = 4'd2,
		opSlt   = 4'd3,
		opSltu  = 4'd4,
		opXor   = 4'd5,
		opSrl   = 4'd6,
		opSra   = 4'd7,
		opOr    = 4'd8,
		opAnd   = 4'd9,
		opPassB = 4'd10
	} aluOpT;

	typedef struct packed {
		logic     regDst;
		logic     branch;
		logic     memRead;
		logic     memWrite;
		logic     memToReg;
		logic     aluSrc;
		logic     regWrite;
		logic     jump;
		logic     inAIsPc;
		aluCntrlT aluCntrl;
	} ctrlT;

	typedef struct packed {
		logic                   valid;
		ctrlT                   ctrl;
		aluOpT                  aluOp;
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       rs1Data;
		logic [`XLEN-1:0]       rs2Data;
		logic [`XLEN-1:0]       imm;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`FUNCT3_W-1:0]   funct3;
	} idExT;

endpackage

`default_nettype wire

/* testbench/decodeStageTb.sv */
`default_nettype none

`include "rvParams.svh"

module decodeStageTb;
	import rvPkg::*;

	localparam int testCycles = 260; // Rough sum over all tests.

	logic        clock, arstN, inValid, stall, flush, wbEn;
	logic [31:0] instr, pc, wbData;
	logic [4:0]  wbAddr;
	logic        outValid, regDst, branch, memRead, memWrite, memToReg;
	logic        aluSrc, regWrite, jump, inAIsPc;
	aluOpT       aluOp;
	logic [31:0] outPc, rs1Data, rs2Data, imm;
	logic [4:0]  rd;
	logic [2:0]  funct3;
	logic [31:0] shadow [32]; // Expected register contents.

	tbClock #(.period(40)) uClock (.clock(clock));

	decodeStage u_dut (.*);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkCtrl(input string name, input ctrlT got, input ctrlT exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkAluOp(input string name, input aluOpT got, input aluOpT exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	// ALU class is internal, so it reads as aluR here.
	function automatic ctrlT seenCtrl();
		return {regDst, branch, memRead, memWrite, memToReg, aluSrc, regWrite, jump,
			inAIsPc, aluR};
	endfunction

	function automatic ctrlT refCtrl(input logic [6:0] op);
		ctrlT c;
		logic load, store, jal, jalr, auipc, writes;
		load   = op == `I_LOAD_FORMAT;
		store  = op == `S_FORMAT;
		jal    = op == `J_FORMAT;
		jalr   = op == `I_JALR_FORMAT;
		auipc  = op == `U_FORMAT_AUIPC;
		writes = op == `R_FORMAT || op == `I_COMP_FORMAT || load || jalr || jal
			|| op == `U_FORMAT_LUI || auipc;
		c = '0;
		c.regDst   = writes;
		c.regWrite = writes;
		c.branch   = op == `B_FORMAT;
		c.memRead  = load;
		c.memToReg = load;
		c.memWrite = store;
		c.aluSrc   = op == `I_COMP_FORMAT || load || store || op == `U_FORMAT_LUI || auipc;
		c.jump     = jal || jalr;
		c.inAIsPc  = jal || jalr || auipc;
		return c;
	endfunction

	function automatic aluOpT refAluOp(input logic [6:0] op, input logic [2:0] f3,
		input logic b30);
		if (op == `B_FORMAT)
			return opSub;
		if (op == `U_FORMAT_LUI)
			return opPassB;
		if (op != `R_FORMAT && op != `I_COMP_FORMAT)
			return opAdd;
		case (f3)
			3'd0: return (b30 && op == `R_FORMAT) ? opSub : opAdd;
			3'd1: return opSll;
			3'd2: return opSlt;
			3'd3: return opSltu;
			3'd4: return opXor;
			3'd5: return b30 ? opSra : opSrl;
			3'd6: return opOr;
			default: return opAnd;
		endcase
	endfunction

	function automatic idExT predict(input logic [31:0] word, input logic [31:0] pcVal,
		input logic valid, input logic [31:0] immVal);
		idExT e;
		e.valid   = valid;
		e.ctrl    = valid ? refCtrl(word[6:0]) : '0;
		e.aluOp   = refAluOp(word[6:0], word[14:12], word[30]);
		e.pc      = pcVal;
		e.rs1Data = shadow[word[19:15]];
		e.rs2Data = shadow[word[24:20]];
		e.imm     = immVal;
		e.rd      = word[11:7];
		e.funct3  = word[14:12];
		return e;
	endfunction

	task automatic compareAll(input idExT e);
		checkWord("outValid", {31'b0, outValid}, {31'b0, e.valid});
		checkCtrl("ctrl", seenCtrl(), e.ctrl);
		checkAluOp("aluOp", aluOp, e.aluOp);
		checkWord("outPc", outPc, e.pc);
		checkWord("rs1Data", rs1Data, e.rs1Data);
		checkWord("rs2Data", rs2Data, e.rs2Data);
		checkWord("imm", imm, e.imm);
		checkWord("rd", {27'b0, rd}, {27'b0, e.rd});
		checkWord("funct3", {29'b0, funct3}, {29'b0, e.funct3});
	endtask

	task automatic checkBubble();
		checkWord("outValid", {31'b0, outValid}, 32'd0);
		checkCtrl("ctrl", seenCtrl(), '0);
	endtask

	task automatic present(input logic [31:0] word, input logic valid,
		output logic [31:0] pcVal);
		pcVal = $urandom & 32'hffff_fffc; // Word aligned.
		@(posedge clock);
		instr   <= word;
		pc      <= pcVal;
		inValid <= valid;
	endtask

	task automatic issue(input logic [31:0] word, input logic valid, input logic [31:0] immVal);
		logic [31:0] pcVal;
		present(word, valid, pcVal);
		@(posedge clock);
		@(negedge clock);
		compareAll(predict(word, pcVal, valid, immVal));
	endtask

	task automatic writeReg(input logic [4:0] a, input logic [31:0] d);
		@(posedge clock);
		wbEn   <= 1'b1;
		wbAddr <= a;
		wbData <= d;
		@(posedge clock);
		wbEn <= 1'b0;
		if (a != 5'd0)
			shadow[a] = d;
	endtask

	task automatic resetTests();
		@(negedge clock);
		checkBubble();
		issue({7'b0, 10'($urandom), 3'b000, 5'($urandom), `R_FORMAT}, 1'b1, 32'd0);
	endtask

	task automatic aluTests();
		logic [11:0] i12;
		for (int f = 0; f < 16; f++) begin
			i12 = 12'($urandom);
			i12[10] = f[0]; // Lands on instruction bit 30.
			issue({1'b0, f[0], 5'b0, 5'($urandom), 5'($urandom), f[3:1], 5'($urandom),
				`R_FORMAT}, 1'b1, 32'd0);
			issue({i12, 5'($urandom), f[3:1], 5'($urandom), `I_COMP_FORMAT}, 1'b1,
				{{20{i12[11]}}, i12});
		end
	endtask

	task automatic memTests();
		logic [11:0] i12;
		logic [31:0] ext;
		for (int k = 0; k < 4; k++) begin
			i12 = 12'($urandom);
			i12[11] = k[0];
			ext = {{20{i12[11]}}, i12};
			issue({i12, 5'($urandom), 3'($urandom), 5'($urandom), `I_LOAD_FORMAT}, 1'b1, ext);
			issue({i12[11:5], 5'($urandom), 5'($urandom), 3'($urandom), i12[4:0], `S_FORMAT},
				1'b1, ext);
			issue({i12, 5'($urandom), 3'b000, 5'($urandom), `I_JALR_FORMAT}, 1'b1, ext);
		end
	endtask

	task automatic flowTests();
		logic [12:0] b13;
		logic [20:0] j21;
		logic [19:0] u20;
		for (int k = 0; k < 4; k++) begin
			b13 = {k[0], 11'($urandom), 1'b0};
			j21 = {k[0], 19'($urandom), 1'b0};
			u20 = 20'($urandom);
			issue({b13[12], b13[10:5], 5'($urandom), 5'($urandom), 3'($urandom), b13[4:1],
				b13[11], `B_FORMAT}, 1'b1, {{19{b13[12]}}, b13});
			issue({j21[20], j21[10:1], j21[11], j21[19:12], 5'($urandom), `J_FORMAT}, 1'b1,
				{{11{j21[20]}}, j21});
			issue({u20, 5'($urandom), `U_FORMAT_LUI}, 1'b1, {u20, 12'b0});
			issue({u20, 5'($urandom), `U_FORMAT_AUIPC}, 1'b1, {u20, 12'b0});
		end
	endtask

	task automatic regFileTests();
		logic [4:0]  a;
		logic [31:0] word, d, pcVal;
		repeat (4) begin
			a = 5'($urandom);
			writeReg(a, $urandom);
			issue({7'b0, 5'($urandom), a, 3'b000, 5'($urandom), `R_FORMAT}, 1'b1, 32'd0);
		end
		writeReg(5'd0, $urandom | 32'd1);
		issue({7'b0, 5'd0, 5'd0, 3'b000, 5'($urandom), `R_FORMAT}, 1'b1, 32'd0);
		a = 5'($urandom) | 5'd1;
		d = $urandom;
		word = {7'b0, 5'($urandom), a, 3'b000, 5'($urandom), `R_FORMAT};
		present(word, 1'b1, pcVal);
		wbEn   <= 1'b1; // Written on the same edge that reads it.
		wbAddr <= a;
		wbData <= d;
		@(posedge clock);
		wbEn <= 1'b0;
		shadow[a] = d;
		@(negedge clock);
		compareAll(predict(word, pcVal, 1'b1, 32'd0));
	endtask

	task automatic stallFlushTests();
		logic [31:0] wordA, wordB, pcA, pcB;
		idExT        keep;
		wordA = {7'b0, 10'($urandom), 3'b111, 5'($urandom), `R_FORMAT};
		wordB = {7'b0100000, 10'($urandom), 3'b000, 5'($urandom), `R_FORMAT};
		present(wordA, 1'b1, pcA);
		@(posedge clock);
		keep = predict(wordA, pcA, 1'b1, 32'd0);
		present(wordB, 1'b1, pcB);
		stall <= 1'b1;
		@(posedge clock);
		@(negedge clock);
		compareAll(keep);
		@(posedge clock);
		flush <= 1'b1;
		@(posedge clock);
		@(negedge clock);
		checkBubble();
		@(posedge clock);
		flush <= 1'b0;
		stall <= 1'b0;
		@(posedge clock);
		@(negedge clock);
		compareAll(predict(wordB, pcB, 1'b1, 32'd0));
		issue(wordB, 1'b0, 32'd0);
	endtask

	task automatic unknownTests();
		logic [6:0] ops [4];
		ops = '{7'b0001011, 7'b0001111, 7'b1110011, 7'b1111111};
		for (int k = 0; k < 8; k++)
			issue({25'($urandom), ops[2'(k)]}, k[0], 32'd0);
	endtask

	initial begin
		void'($urandom(32'h3ec4));
		foreach (shadow[i])
			shadow[i] = '0;
		arstN   = 1'b0;
		instr   = '0;
		pc      = '0;
		inValid = 1'b0;
		stall   = 1'b0;
		flush   = 1'b0;
		wbEn    = 1'b0;
		wbAddr  = '0;
		wbData  = '0;
		repeat (5) @(posedge clock);
		arstN <= 1'b1;
		resetTests();
		for (int i = 1; i < 32; i++)
			writeReg(5'(i), $urandom);
		aluTests();
		memTests();
		flowTests();
		regFileTests();
		stallFlushTests();
		unknownTests();
		$display("TEST PASS");
		$finish;
	end

	initial begin
		#(testCycles * 40 * 2);
		abortRun("Timeout, the tests did not finish in the expected time.");
	end

endmodule

`default_nettype wire

/* testbench/tbClock.sv */
`default_nettype none

module tbClock #(parameter int period = 40) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

endmodule

`default_nettype wire
